/* dataIoPkg.sv */
/*
 * Shared constants and types for the SPI file-download port.
 * Imported by the receiver, the top level and the testbench.
 */

`default_nettype none

package dataIoPkg;

	// **************************************************************************
	// command codes sent by the io controller as the first byte of a message
	// **************************************************************************

	// start/stop of a file transfer, bit 0 of the next byte selects which
	localparam logic [7:0] CMD_FILE_TX = 8'h53;
	// every following byte is a file byte
	localparam logic [7:0] CMD_FILE_TX_DAT = 8'h54;
	// next byte selects the menu index
	localparam logic [7:0] CMD_FILE_INDEX = 8'h55;

	// **************************************************************************
	// widths and default load addresses
	// **************************************************************************

	// ram address and byte count width
	localparam int ADDR_W = 25;
	// menu index width
	localparam int INDEX_W = 5;

	// index 0 loads here (1.5 MB)
	localparam logic [ADDR_W-1:0] BASE_INDEX0 = 25'h180000;
	// any other index loads here (2 MB)
	localparam logic [ADDR_W-1:0] BASE_OTHER = 25'h200000;

	// control view of a payload byte
	// low bit of field doubles as the start flag
	typedef struct packed {
		logic [2:0] rsvd;
		logic [4:0] field;
	} ctrlWord_t;

	// a payload byte is either raw file data or a control word
	typedef union packed {
		logic [7:0] raw;
		ctrlWord_t  ctrl;
	} payloadByte_u;

endpackage

`default_nettype wire

/* spiCommandRx.sv */
/*
 * SPI mode 0 receiver in the sck domain. Decodes the command byte and the
 * payload bytes behind it, holds the menu index and the download flag, and
 * flips a toggle for every stored file byte.
 */

`timescale 1ns/1ps
`default_nettype none

module spiCommandRx #(
	parameter int IndexW = dataIoPkg::INDEX_W
) (
	// asynchronous reset, active high
	input  wire               ss,
	// spi link from the io controller
	input  wire               sck,
	input  wire               spiSelN,
	input  wire               spiSdi,
	// last received file byte
	output logic [7:0]        byteData,
	// inverts once per new file byte
	output logic              byteToggle,
	// download in progress
	output logic              dlActive,
	// menu index of the file
	output logic [IndexW-1:0] index
);

	import dataIoPkg::*;

	// bit position, 0..7 for the command then 8..15 per payload byte
	logic [3:0]   bitCnt;
	// async clear for the bit counter
	logic         cntClr;
	// first seven bits of the byte in flight
	logic [6:0]   shiftReg;
	// command of the current message
	logic [7:0]   cmd;
	// byte completed on this edge, seen through both views
	payloadByte_u rxByte;
	// edge that samples bit 7 of a payload byte
	logic         byteDone;

	// the last bit is taken straight from the pin so the byte is usable
	// on the same edge that completes it
	assign rxByte.raw = {shiftReg, spiSdi};
	assign byteDone   = (bitCnt == 4'd15);

	// deselect puts the counter back to the start of a command byte
	assign cntClr = ss | spiSelN;

	// **************************************************************************
	// bit counter
	// **************************************************************************

	// count 0-7 for the command, then 8-15 over and over for payload
	always_ff @(posedge sck or posedge cntClr) begin
		if (cntClr) begin
			bitCnt <= '0;
		end else if (bitCnt == 4'd15) begin
			bitCnt <= 4'd8;
		end else begin
			bitCnt <= bitCnt + 4'd1;
		end
	end

	// **************************************************************************
	// shifter and command capture
	// **************************************************************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			shiftReg <= '0;
			cmd      <= '0;
		end else begin
			// msb first
			shiftReg <= rxByte.raw[6:0];
			// command byte finishes on the eighth edge
			if (bitCnt == 4'd7) begin
				cmd <= rxByte.raw;
			end
		end
	end

	// **************************************************************************
	// payload decode
	// **************************************************************************

	always_ff @(posedge sck or posedge ss) begin
		if (ss) begin
			byteData   <= '0;
			byteToggle <= 1'b0;
			dlActive   <= 1'b0;
			index      <= '0;
		end else if (byteDone) begin
			case (cmd)
				CMD_FILE_INDEX: begin
					// menu index sits in the low field bits
					index <= rxByte.ctrl.field[IndexW-1:0];
				end
				CMD_FILE_TX: begin
					// 1 starts a download, 0 ends it
					dlActive <= rxByte.ctrl.field[0];
				end
				CMD_FILE_TX_DAT: begin
					// file bytes outside a download are dropped
					if (dlActive) begin
						byteData   <= rxByte.raw;
						byteToggle <= ~byteToggle;
					end
				end
				default: begin
					// unknown command, payload ignored
				end
			endcase
		end
	end

	// **************************************************************************
	// checks
	// **************************************************************************

	// the writer reads index unsynchronised when a download starts,
	// so the controller must leave it alone for the whole download
	indexHeldDuringDownload: assert property (
		@(posedge sck) disable iff (ss)
		dlActive |=> $stable(index)
	) else $error("index changed while a download was active");

endmodule

`default_nettype wire

/* downloadWriter.sv */
/*
 * clk-domain side of the download port. Synchronises the byte toggle and
 * the download flag from the sck domain, then issues one ram write per
 * file byte at consecutive addresses and keeps the byte count.
 */

`timescale 1ns/1ps
`default_nettype none

module downloadWriter #(
	parameter int               AddrW = dataIoPkg::ADDR_W,
	parameter logic [AddrW-1:0] Base0 = dataIoPkg::BASE_INDEX0,
	parameter logic [AddrW-1:0] Base1 = dataIoPkg::BASE_OTHER
) (
	input  wire                            clk,
	// asynchronous reset, active high
	input  wire                            ss,
	// from the sck domain, byteData stable for 7 sck after a toggle
	input  wire [7:0]                      byteData,
	input  wire                            byteToggle,
	input  wire                            dlActive,
	// quasi-static, only read when a download starts
	input  wire [dataIoPkg::INDEX_W-1:0]   index,
	// external ram write port
	output logic                           wr,
	output logic [AddrW-1:0]               a,
	output logic [7:0]                     d,
	// status
	output logic                           downloading,
	output logic [AddrW-1:0]               size
);

	// byte toggle synchroniser plus one history flop
	logic toggleMeta;
	logic toggleSync;
	logic togglePrev;
	// download flag synchroniser, downloading is its history flop
	logic dlMeta;
	logic dlSync;
	// a new byte has crossed into the clk domain
	logic byteSeen;
	// download just started
	logic dlRise;

	assign byteSeen = toggleSync ^ togglePrev;
	assign dlRise   = dlSync & ~downloading;

	// **************************************************************************
	// clock domain crossing
	// **************************************************************************

	// two flops each, the third stage feeds edge detection
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			toggleMeta  <= 1'b0;
			toggleSync  <= 1'b0;
			togglePrev  <= 1'b0;
			dlMeta      <= 1'b0;
			dlSync      <= 1'b0;
			downloading <= 1'b0;
		end else begin
			toggleMeta  <= byteToggle;
			toggleSync  <= toggleMeta;
			togglePrev  <= toggleSync;
			dlMeta      <= dlActive;
			dlSync      <= dlMeta;
			// 2 to 3 clk behind dlActive
			downloading <= dlSync;
		end
	end

	// **************************************************************************
	// write pulse and data
	// **************************************************************************

	// one wr per toggle change, data latched alongside
	// byteData has settled long before the toggle gets through
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			wr <= 1'b0;
			d  <= '0;
		end else begin
			wr <= byteSeen;
			if (byteSeen) begin
				d <= byteData;
			end
		end
	end

	// **************************************************************************
	// address and byte count
	// **************************************************************************

	// a holds the address of the write in progress and steps after it
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			a    <= '0;
			size <= '0;
		end else if (dlRise) begin
			// index 0 has its own load area
			if (index == '0) begin
				a <= Base0;
			end else begin
				a <= Base1;
			end
			size <= '0;
		end else if (wr) begin
			a    <= a + AddrW'(1);
			size <= size + AddrW'(1);
		end
	end

	// **************************************************************************
	// checks
	// **************************************************************************

	// each toggle change makes exactly one single-cycle write
	wrSinglePulse: assert property (
		@(posedge clk) disable iff (ss)
		wr |=> !wr
	) else $error("wr held high for more than one cycle");

	// the receiver only toggles inside a download, and the stop message
	// comes a whole byte after the last data byte
	wrOnlyWhileDownloading: assert property (
		@(posedge clk) disable iff (ss)
		wr |-> downloading
	) else $error("ram write outside of a download");

endmodule

`default_nettype wire

/* dataIo.sv */
/*
 * Top level of the SPI file-download port. Joins the sck-domain command
 * receiver to the clk-domain ram writer and brings out the ram port.
 */

`timescale 1ns/1ps
`default_nettype none

module dataIo #(
	// ram address and byte count width
	parameter int               AddrW = dataIoPkg::ADDR_W,
	// load address for index 0
	parameter logic [AddrW-1:0] Base0 = dataIoPkg::BASE_INDEX0,
	// load address for every other index
	parameter logic [AddrW-1:0] Base1 = dataIoPkg::BASE_OTHER
) (
	// system clock and asynchronous reset, active high
	input  wire                            clk,
	input  wire                            ss,
	// spi link from the io controller, mode 0
	input  wire                            sck,
	input  wire                            spiSelN,
	input  wire                            spiSdi,
	// external ram write port, clk domain
	output wire                            wr,
	output wire [AddrW-1:0]                a,
	output wire [7:0]                      d,
	// status
	output wire                            downloading,
	output wire [AddrW-1:0]                size,
	output wire [dataIoPkg::INDEX_W-1:0]   index
);

	import dataIoPkg::*;

	// sck-domain registers handed to the writer
	logic [7:0] byteData;
	logic       byteToggle;
	logic       dlActive;

	// **************************************************************************
	// spi side
	// **************************************************************************

	spiCommandRx #(
		.IndexW     (INDEX_W)
	) u_rx (
		.ss         (ss),
		.sck        (sck),
		.spiSelN    (spiSelN),
		.spiSdi     (spiSdi),
		.byteData   (byteData),
		.byteToggle (byteToggle),
		.dlActive   (dlActive),
		.index      (index)
	);

	// **************************************************************************
	// ram side
	// **************************************************************************

	// index goes straight across, it is frozen for the whole download
	downloadWriter #(
		.AddrW       (AddrW),
		.Base0       (Base0),
		.Base1       (Base1)
	) u_writer (
		.clk         (clk),
		.ss          (ss),
		.byteData    (byteData),
		.byteToggle  (byteToggle),
		.dlActive    (dlActive),
		.index       (index),
		.wr          (wr),
		.a           (a),
		.d           (d),
		.downloading (downloading),
		.size        (size)
	);

endmodule

`default_nettype wire

/* tbSpiHost.sv */
/*
 * SPI mode 0 controller model for the download port testbench.
 * All pins change on the rising clk edge and sck runs at a quarter of clk.
 * The testbench calls its tasks hierarchically to send bytes and messages.
 */

`timescale 1ns/1ps
`default_nettype none

module tbSpiHost (
	input  wire  clk,
	// spi pins toward the DUT
	output logic sck,
	output logic spiSelN,
	output logic spiSdi
);

	// link idles deselected with sck low
	initial begin
		sck     = 1'b0;
		spiSelN = 1'b1;
		spiSdi  = 1'b0;
	end

	// **************************************************************************
	// framing
	// **************************************************************************

	// select the receiver, sck stays low until the first bit
	task automatic beginMessage();
		@(posedge clk);
		spiSelN <= 1'b0;
		sck     <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// bring sck low before deselecting, then leave an idle gap
	task automatic endMessage();
		@(posedge clk);
		sck <= 1'b0;
		@(posedge clk);
		spiSelN <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	// **************************************************************************
	// bit and byte level
	// **************************************************************************

	// first n bits of b, msb first
	// one sck period is four clk cycles
	task automatic sendBits(input logic [7:0] b, input int n);
		for (int i = 7; i > 7 - n; i--) begin
			// low half, data changes here
			@(posedge clk);
			sck    <= 1'b0;
			spiSdi <= b[i];
			@(posedge clk);
			// high half, receiver samples on this edge
			@(posedge clk);
			sck <= 1'b1;
			@(posedge clk);
		end
	endtask

	task automatic sendByte(input logic [7:0] b);
		sendBits(b, 8);
	endtask

	// **************************************************************************
	// messages
	// **************************************************************************

	// command plus one payload byte as one whole message
	task automatic sendCommand(input logic [7:0] cmd, input logic [7:0] payload);
		beginMessage();
		sendByte(cmd);
		sendByte(payload);
		endMessage();
	endtask

	// n bits of a byte, then deselect in the middle of it
	task automatic abortByte(input logic [7:0] b, input int n);
		sendBits(b, n);
		endMessage();
	endtask

endmodule

`default_nettype wire

/* dataIoTb.sv */
/*
 * Top testbench for the SPI file-download port. Runs a table of file
 * transfers through an SPI controller model and checks every ram write,
 * the download flag, the byte count and the index against the table.
 */

`timescale 1ns/1ps
`default_nettype none

module dataIoTb;

	import dataIoPkg::*;

	localparam int         NumRows    = 5;
	// not one of the three known commands
	localparam logic [7:0] CmdUnknown = 8'h99;

	logic                 clk;
	logic                 ss;
	wire                  sck;
	wire                  spiSelN;
	wire                  spiSdi;
	wire                  wr;
	wire  [ADDR_W-1:0]    a;
	wire  [7:0]           d;
	wire                  downloading;
	wire  [ADDR_W-1:0]    size;
	wire  [INDEX_W-1:0]   index;

	// transfer table, one column per file
	string testName [NumRows] = '{"idx0_short", "idx3_file", "idx0_abort",
		"idx17_abort", "idx31_file"};
	int    rowIndex [NumRows] = '{0, 3, 0, 17, 31};
	int    rowCount [NumRows] = '{6, 10, 5, 7, 4};
	bit    rowAbort [NumRows] = '{0, 0, 1, 1, 0};

	// expected ram writes in order
	logic [ADDR_W-1:0] expAddr [$];
	logic [7:0]        expByte [$];
	logic [ADDR_W-1:0] nextAddr;
	logic [7:0]        nextByte;

	string        curName;
	int           writesSeen;
	int           cycleCount = 0;
	int           cycleLimit = 0;
	logic [31:0]  rand32;
	payloadByte_u ctrlByte;

	// 8 ns period
	initial clk = 1'b0;
	always #4 clk = ~clk;

	dataIo u_dut (
		.clk         (clk),
		.ss          (ss),
		.sck         (sck),
		.spiSelN     (spiSelN),
		.spiSdi      (spiSdi),
		.wr          (wr),
		.a           (a),
		.d           (d),
		.downloading (downloading),
		.size        (size),
		.index       (index)
	);

	tbSpiHost u_host (
		.clk     (clk),
		.sck     (sck),
		.spiSelN (spiSelN),
		.spiSdi  (spiSdi)
	);

	// **************************************************************************
	// compare tasks
	// **************************************************************************

	task automatic checkAddr(input string name, input logic [ADDR_W-1:0] expected,
			input logic [ADDR_W-1:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "data byte mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	// byte counts and the index, zero extended
	task automatic checkCount(input string name, input logic [ADDR_W-1:0] expected,
			input logic [ADDR_W-1:0] actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %0d, actual %0d", name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic checkResetState(input string name);
		checkFlag({name, " wr"}, 1'b0, wr);
		checkFlag({name, " downloading"}, 1'b0, downloading);
		checkCount({name, " index"}, '0, index);
		checkCount({name, " size"}, '0, size);
	endtask

	// **************************************************************************
	// ram port monitor
	// **************************************************************************

	// wr, a and d are read before the edge updates them
	always @(posedge clk) begin
		if (!ss && wr === 1'b1) begin
			if (expByte.size() == 0) begin
				$display("unexpected ram write at address %h in %s", a, curName);
				$display("TEST FAIL");
				$fatal(1, "write with nothing expected");
			end else begin
				nextAddr = expAddr.pop_front();
				nextByte = expByte.pop_front();
				checkAddr({curName, " addr"}, nextAddr, a);
				checkByte({curName, " data"}, nextByte, d);
				writesSeen = writesSeen + 1;
			end
		end
	end

	// hard stop in case a wait never ends
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d clock cycles, the run did not finish", cycleCount);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	// **************************************************************************
	// stimulus
	// **************************************************************************

	task automatic waitDownloading(input logic value);
		while (downloading !== value) @(posedge clk);
	endtask

	// bytes that must not reach the ram
	task automatic runIgnored(input string name);
		logic [ADDR_W-1:0] sizeBefore;
		int                seenBefore;
		curName    = name;
		sizeBefore = size;
		seenBefore = writesSeen;
		// file bytes with no download active
		u_host.beginMessage();
		u_host.sendByte(CMD_FILE_TX_DAT);
		repeat (3) begin
			rand32 = $urandom;
			u_host.sendByte(rand32[7:0]);
		end
		u_host.endMessage();
		u_host.sendCommand(CmdUnknown, 8'h01);
		// well past the synchroniser delay
		repeat (8) @(posedge clk);
		checkCount({name, " writes"}, seenBefore, writesSeen);
		checkCount({name, " size"}, sizeBefore, size);
		checkFlag({name, " downloading"}, 1'b0, downloading);
	endtask

	task automatic runRow(input int r);
		logic [ADDR_W-1:0] base;
		curName = testName[r];
		// index message through the control view
		ctrlByte.raw        = '0;
		ctrlByte.ctrl.field = 5'(rowIndex[r]);
		u_host.sendCommand(CMD_FILE_INDEX, ctrlByte.raw);
		checkCount({curName, " index"}, rowIndex[r], index);
		base = (rowIndex[r] == 0) ? BASE_INDEX0 : BASE_OTHER;
		// start flag set
		ctrlByte.raw        = '0;
		ctrlByte.ctrl.field = 5'd1;
		u_host.sendCommand(CMD_FILE_TX, ctrlByte.raw);
		waitDownloading(1'b1);
		checkCount({curName, " size at start"}, '0, size);
		writesSeen = 0;
		u_host.beginMessage();
		u_host.sendByte(CMD_FILE_TX_DAT);
		for (int k = 0; k < rowCount[r]; k++) begin
			rand32 = $urandom;
			expAddr.push_back(base + ADDR_W'(k));
			expByte.push_back(rand32[7:0]);
			u_host.sendByte(rand32[7:0]);
		end
		if (rowAbort[r]) begin
			// five bits of one more byte, then deselect
			rand32 = $urandom;
			u_host.abortByte(rand32[7:0], 5);
		end else begin
			u_host.endMessage();
		end
		// stop, start flag clear
		ctrlByte.raw = '0;
		u_host.sendCommand(CMD_FILE_TX, ctrlByte.raw);
		waitDownloading(1'b0);
		checkCount({curName, " writes"}, rowCount[r], writesSeen);
		checkCount({curName, " size"}, rowCount[r], size);
		checkCount({curName, " index after"}, rowIndex[r], index);
	endtask

	initial begin
		rand32 = $urandom(92606);
		// each byte is 32 clk, times 4, with 8 overhead bytes per row
		cycleLimit = 2000 + 2 * 8 * 32 * 4;
		for (int r = 0; r < NumRows; r++) begin
			cycleLimit = cycleLimit + (rowCount[r] + 8) * 32 * 4;
		end
		ss         = 1'b1;
		writesSeen = 0;
		curName    = "reset";
		repeat (10) begin
			@(posedge clk);
			checkResetState("reset");
		end
		ss <= 1'b0;
		@(posedge clk);
		checkResetState("after_reset");
		runIgnored("ignored_idle");
		for (int r = 0; r < NumRows; r++) begin
			runRow(r);
		end
		runIgnored("ignored_after_stop");
		if (expByte.size() != 0) begin
			$display("%0d expected ram writes never happened", expByte.size());
			$display("TEST FAIL");
			$fatal(1, "missing writes");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
dataIoPkg.sv
spiCommandRx.sv
downloadWriter.sv
dataIo.sv
tbSpiHost.sv
dataIoTb.sv

/* Bender.yml */
package:
  name: data_io

sources:
  - dataIoPkg.sv
  - spiCommandRx.sv
  - downloadWriter.sv
  - dataIo.sv
  - target: test
    files:
      - tbSpiHost.sv
      - dataIoTb.sv
